/* source/axis_cfg.svh */
`ifndef AXIS_CFG_SVH
`define AXIS_CFG_SVH

// Stream widths
`define AXIS_NARROW_W 64
`define AXIS_WIDE_W 256

// Derived strobe widths and lane count
`define AXIS_NARROW_STRB_W (`AXIS_NARROW_W / 8)
`define AXIS_WIDE_STRB_W (`AXIS_WIDE_W / 8)
`define AXIS_LANES (`AXIS_WIDE_W / `AXIS_NARROW_W)

// Destination MAC, then source MAC with EtherType
`define HDR_WORD_0 64'hEFBEFECAFECAFECA
`define HDR_WORD_1 64'h00000008EFBEEFBE

`define MAX_PAYLOAD_BEATS 32

`endif

/* source/axis_pkg.sv */
`include "axis_cfg.svh"

package axis_pkg;

    ////////////////////
    // Stream beat types
    ////////////////////

    // One narrow beat as it travels on the 64-bit side
    typedef struct packed {
        logic [`AXIS_NARROW_W-1:0]      data;
        logic [`AXIS_NARROW_STRB_W-1:0] strb;
        logic                           last;
    } narrow_beat_t;

    // Selects one narrow lane inside a wide beat
    typedef logic [$clog2(`AXIS_LANES)-1:0] lane_idx_t;

endpackage

/* source/frame_pkg.sv */
`include "axis_cfg.svh"

package frame_pkg;

    ////////////////////
    // Generator types
    ////////////////////

    // Generator FSM, headers first and payload after
    typedef enum logic [1:0] {
        IDLE,
        HEADER_0,
        HEADER_1,
        PAYLOAD
    } gen_state_e;

    // Payload beat count, wide enough for MAX_PAYLOAD_BEATS
    typedef logic [$clog2(`MAX_PAYLOAD_BEATS + 1)-1:0] payload_len_t;

endpackage

/* source/axis_if.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

interface axis_if #(
    parameter int W = `AXIS_NARROW_W
);

    logic [W-1:0]   tdata;
    logic [W/8-1:0] tstrb;
    logic           tvalid;
    logic           tready;
    logic           tlast;

    // Producer side
    modport source (
        output tdata,
        output tstrb,
        output tvalid,
        output tlast,
        input  tready
    );

    // Consumer side
    modport sink (
        input  tdata,
        input  tstrb,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

/* source/frame_gen.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

module frame_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_start,
    input  frame_pkg::payload_len_t payload_beats,
    output logic                    busy,
    axis_if.source                  out
);

    localparam int BYTES = `AXIS_NARROW_W / 8;

    frame_pkg::gen_state_e   state;
    frame_pkg::payload_len_t beat_cnt;
    frame_pkg::payload_len_t last_idx;
    frame_pkg::payload_len_t start_last_idx;
    logic                    start_ok;
    logic                    beat_done;
    logic                    final_beat;

    assign start_ok   = frame_start && (state == frame_pkg::IDLE);
    assign beat_done  = out.tvalid && out.tready;
    assign final_beat = (state == frame_pkg::PAYLOAD) && (beat_cnt == last_idx);
    assign busy       = (state != frame_pkg::IDLE);

    // Index of the final payload beat, zero length counts as one beat
    always_comb begin
        if (payload_beats == '0) begin
            start_last_idx = '0;
        end else if (payload_beats > frame_pkg::payload_len_t'(`MAX_PAYLOAD_BEATS)) begin
            start_last_idx = frame_pkg::payload_len_t'(`MAX_PAYLOAD_BEATS - 1);
        end else begin
            start_last_idx = payload_beats - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            last_idx <= start_last_idx;
        end
    end

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= frame_pkg::IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                frame_pkg::IDLE: begin
                    if (start_ok) begin
                        state    <= frame_pkg::HEADER_0;
                        beat_cnt <= '0;
                    end
                end
                frame_pkg::HEADER_0: begin
                    if (beat_done) begin
                        state <= frame_pkg::HEADER_1;
                    end
                end
                frame_pkg::HEADER_1: begin
                    if (beat_done) begin
                        state <= frame_pkg::PAYLOAD;
                    end
                end
                frame_pkg::PAYLOAD: begin
                    if (beat_done) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (final_beat) begin
                            state <= frame_pkg::IDLE;
                        end
                    end
                end
                default: state <= frame_pkg::IDLE;
            endcase
        end
    end

    // Beat contents come from registered state only
    always_comb begin
        out.tvalid = busy;
        out.tstrb  = '1;
        out.tlast  = final_beat;
        case (state)
            frame_pkg::HEADER_0: out.tdata = `HDR_WORD_0;
            frame_pkg::HEADER_1: out.tdata = `HDR_WORD_1;
            // Running byte count repeated across the word
            frame_pkg::PAYLOAD:  out.tdata = {BYTES{{2'b00, beat_cnt}}};
            default:             out.tdata = '0;
        endcase
    end

endmodule

/* source/axis_upsizer.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

module axis_upsizer (
    input  logic   clk,
    input  logic   reset,
    axis_if.sink   s,
    axis_if.source m
);

    localparam int NW    = `AXIS_NARROW_W;
    localparam int NS    = `AXIS_NARROW_STRB_W;
    localparam int LANES = `AXIS_LANES;

    axis_pkg::narrow_beat_t lane_q [LANES];
    axis_pkg::narrow_beat_t in_beat;
    axis_pkg::lane_idx_t    fill_idx;
    logic                   accept;
    logic                   closing;

    logic [`AXIS_WIDE_W-1:0]      pack_data;
    logic [`AXIS_WIDE_STRB_W-1:0] pack_strb;

    logic [`AXIS_WIDE_W-1:0]      wide_data_q;
    logic [`AXIS_WIDE_STRB_W-1:0] wide_strb_q;
    logic                         wide_last_q;
    logic                         wide_valid_q;

    // Take a narrow beat when the wide register is free or draining
    assign s.tready = !wide_valid_q || m.tready;
    assign accept   = s.tvalid && s.tready;
    assign closing  = (fill_idx == axis_pkg::lane_idx_t'(LANES - 1)) || s.tlast;

    always_comb begin
        in_beat.data = s.tdata;
        in_beat.strb = s.tstrb;
        in_beat.last = s.tlast;
    end

    ////////////////////
    // Wide beat assembly
    ////////////////////

    // Stored lanes below the fill point, incoming beat at it, zeros above
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (i < int'(fill_idx)) begin
                pack_data[i*NW +: NW] = lane_q[i].data;
                pack_strb[i*NS +: NS] = lane_q[i].strb;
            end else if (i == int'(fill_idx)) begin
                pack_data[i*NW +: NW] = in_beat.data;
                pack_strb[i*NS +: NS] = in_beat.strb;
            end else begin
                pack_data[i*NW +: NW] = '0;
                pack_strb[i*NS +: NS] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !closing) begin
            lane_q[fill_idx] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_idx     <= '0;
            wide_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                fill_idx <= closing ? '0 : fill_idx + 1'b1;
            end
            if (accept && closing) begin
                wide_valid_q <= 1'b1;
            end else if (m.tready) begin
                wide_valid_q <= 1'b0;
            end
        end
    end

    // Output register, loaded when a wide beat closes
    always_ff @(posedge clk) begin
        if (accept && closing) begin
            wide_data_q <= pack_data;
            wide_strb_q <= pack_strb;
            wide_last_q <= in_beat.last;
        end
    end

    assign m.tdata  = wide_data_q;
    assign m.tstrb  = wide_strb_q;
    assign m.tlast  = wide_last_q;
    assign m.tvalid = wide_valid_q;

endmodule

/* source/axis_downsizer.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

module axis_downsizer (
    input  logic                           clk,
    input  logic                           reset,
    axis_if.sink                           s,
    output logic [`AXIS_NARROW_W-1:0]      m_tdata,
    output logic [`AXIS_NARROW_STRB_W-1:0] m_tstrb,
    output logic                           m_tvalid,
    output logic                           m_tlast,
    input  logic                           m_tready
);

    localparam int NW    = `AXIS_NARROW_W;
    localparam int NS    = `AXIS_NARROW_STRB_W;
    localparam int LANES = `AXIS_LANES;

    logic [`AXIS_WIDE_W-1:0]      buf_data;
    logic [`AXIS_WIDE_STRB_W-1:0] buf_strb;
    logic                         buf_last;
    axis_pkg::lane_idx_t          cur_idx;
    axis_pkg::lane_idx_t          first_idx;
    axis_pkg::lane_idx_t          next_idx;
    axis_pkg::narrow_beat_t       out_q;
    logic                         out_valid;
    logic                         out_free;
    logic                         has_next;
    logic                         accept;

    // Any nonempty lane at index lo or above
    function automatic logic lane_from(input logic [`AXIS_WIDE_STRB_W-1:0] strb, input int lo);
        logic found;
        found = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (i >= lo && |strb[i*NS +: NS]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Lowest nonempty lane at index lo or above
    function automatic axis_pkg::lane_idx_t first_lane(
        input logic [`AXIS_WIDE_STRB_W-1:0] strb,
        input int                           lo
    );
        axis_pkg::lane_idx_t idx;
        logic                found;
        idx   = '0;
        found = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (!found && i >= lo && |strb[i*NS +: NS]) begin
                idx   = axis_pkg::lane_idx_t'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    assign out_free  = !out_valid || m_tready;
    assign has_next  = out_valid && lane_from(buf_strb, int'(cur_idx) + 1);
    assign next_idx  = first_lane(buf_strb, int'(cur_idx) + 1);
    assign first_idx = first_lane(s.tstrb, 0);

    // Next wide beat enters as the last lane leaves
    assign s.tready = out_free && !has_next;
    assign accept   = s.tvalid && s.tready;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_data <= s.tdata;
            buf_strb <= s.tstrb;
            buf_last <= s.tlast;
        end
    end

    ////////////////////
    // Lane stepping
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            cur_idx   <= '0;
        end else if (accept) begin
            out_valid <= |s.tstrb;
            cur_idx   <= first_idx;
        end else if (out_free && has_next) begin
            out_valid <= 1'b1;
            cur_idx   <= next_idx;
        end else if (m_tready) begin
            out_valid <= 1'b0;
        end
    end

    // tlast only on the final nonempty lane of a closing wide beat
    always_ff @(posedge clk) begin
        if (accept) begin
            out_q.data <= s.tdata[first_idx*NW +: NW];
            out_q.strb <= s.tstrb[first_idx*NS +: NS];
            out_q.last <= s.tlast && !lane_from(s.tstrb, int'(first_idx) + 1);
        end else if (out_free && has_next) begin
            out_q.data <= buf_data[next_idx*NW +: NW];
            out_q.strb <= buf_strb[next_idx*NS +: NS];
            out_q.last <= buf_last && !lane_from(buf_strb, int'(next_idx) + 1);
        end
    end

    assign m_tdata  = out_q.data;
    assign m_tstrb  = out_q.strb;
    assign m_tlast  = out_q.last;
    assign m_tvalid = out_valid;

endmodule

/* source/frame_loop_top.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

module frame_loop_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           frame_start,
    input  frame_pkg::payload_len_t        payload_beats,
    output logic                           busy,
    output logic [`AXIS_NARROW_W-1:0]      m_tdata,
    output logic [`AXIS_NARROW_STRB_W-1:0] m_tstrb,
    output logic                           m_tvalid,
    input  logic                           m_tready,
    output logic                           m_tlast
);

    // Generator to upsizer, then upsizer to downsizer
    axis_if #(.W(`AXIS_NARROW_W)) narrow_s ();
    axis_if #(.W(`AXIS_WIDE_W))   wide_s ();

    frame_gen i_frame_gen (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .payload_beats (payload_beats),
        .busy          (busy),
        .out           (narrow_s.source)
    );

    axis_upsizer i_axis_upsizer (
        .clk   (clk),
        .reset (reset),
        .s     (narrow_s.sink),
        .m     (wide_s.source)
    );

    axis_downsizer i_axis_downsizer (
        .clk      (clk),
        .reset    (reset),
        .s        (wide_s.sink),
        .m_tdata  (m_tdata),
        .m_tstrb  (m_tstrb),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tready (m_tready)
    );

endmodule

/* tests/frame_checker.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

module frame_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           frame_start,
    input  frame_pkg::payload_len_t        payload_beats,
    input  logic                           busy,
    input  logic [`AXIS_NARROW_W-1:0]      m_tdata,
    input  logic [`AXIS_NARROW_STRB_W-1:0] m_tstrb,
    input  logic                           m_tvalid,
    input  logic                           m_tready,
    input  logic                           m_tlast,
    output int                             value_errors,
    output int                             stall_errors,
    output int                             reset_errors,
    output int                             extra_beats,
    output int                             pending,
    output int                             frames_started,
    output int                             frames_done
);

    axis_pkg::narrow_beat_t model_q [$];
    axis_pkg::narrow_beat_t held;
    logic                   held_valid;
    logic                   reset_q;

    initial begin
        value_errors   = 0;
        stall_errors   = 0;
        reset_errors   = 0;
        extra_beats    = 0;
        pending        = 0;
        frames_started = 0;
        frames_done    = 0;
        held_valid     = 1'b0;
        reset_q        = 1'b0;
    end

    ////////////////////
    // Expected frames
    ////////////////////

    // Two header words, then byte k repeated across payload beat k
    task automatic push_frame(input frame_pkg::payload_len_t len);
        int                     n;
        logic [7:0]             k_byte;
        axis_pkg::narrow_beat_t beat;
        n = int'(len);
        if (n == 0) begin
            n = 1;
        end
        if (n > `MAX_PAYLOAD_BEATS) begin
            n = `MAX_PAYLOAD_BEATS;
        end
        beat.strb = '1;
        beat.last = 1'b0;
        beat.data = `HDR_WORD_0;
        model_q.push_back(beat);
        beat.data = `HDR_WORD_1;
        model_q.push_back(beat);
        for (int k = 0; k < n; k++) begin
            k_byte    = 8'(k);
            beat.data = {(`AXIS_NARROW_W / 8){k_byte}};
            beat.last = (k == n - 1);
            model_q.push_back(beat);
        end
    endtask

    task automatic check_transfer();
        axis_pkg::narrow_beat_t exp;
        if (model_q.size() == 0) begin
            extra_beats++;
            $display("Unexpected beat at %0t: a beat left the DUT with no frame outstanding",
                     $time);
        end else begin
            exp = model_q.pop_front();
            if (m_tdata !== exp.data || m_tstrb !== exp.strb || m_tlast !== exp.last) begin
                value_errors++;
                $display("error at %0t: got data %h strb %h last %b, expected %h %h %b",
                         $time, m_tdata, m_tstrb, m_tlast, exp.data, exp.strb, exp.last);
            end
        end
        if (m_tlast === 1'b1) begin
            frames_done++;
        end
    endtask

    ////////////////////
    // Port monitor
    ////////////////////

    always @(posedge clk) begin
        // Outputs settled by the previous reset edge must be idle
        if (reset_q && (m_tvalid !== 1'b0 || busy !== 1'b0)) begin
            reset_errors++;
            $display("error at %0t: m_tvalid or busy high around reset", $time);
        end
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            if (frame_start && !busy) begin
                push_frame(payload_beats);
                frames_started++;
            end
            // Beat stalled last cycle must still be offered unchanged
            if (held_valid && (m_tvalid !== 1'b1 || m_tdata !== held.data ||
                               m_tstrb !== held.strb || m_tlast !== held.last)) begin
                stall_errors++;
                $display("error at %0t: output beat changed while stalled", $time);
            end
            if (m_tvalid && m_tready) begin
                check_transfer();
            end
            held_valid = m_tvalid && !m_tready;
            held.data  = m_tdata;
            held.strb  = m_tstrb;
            held.last  = m_tlast;
        end
        reset_q = reset;
        pending = model_q.size();
    end

endmodule

/* tests/tb_frame_loop.sv */
`timescale 1ns/1ps
`include "axis_cfg.svh"

module tb_frame_loop;

    localparam int FRAMES         = 40;
    localparam int MAX_BEATS      = `MAX_PAYLOAD_BEATS + 2;
    localparam int TIMEOUT_CYCLES = FRAMES * MAX_BEATS * 4 + 200;
    localparam int DRAIN_LIMIT    = MAX_BEATS * 4;

    logic                           clk;
    logic                           reset;
    logic                           frame_start;
    frame_pkg::payload_len_t        payload_beats;
    logic                           busy;
    logic [`AXIS_NARROW_W-1:0]      m_tdata;
    logic [`AXIS_NARROW_STRB_W-1:0] m_tstrb;
    logic                           m_tvalid;
    logic                           m_tready;
    logic                           m_tlast;

    int          value_errors;
    int          stall_errors;
    int          reset_errors;
    int          extra_beats;
    int          pending;
    int          frames_started;
    int          frames_done;
    int          other_failures;
    int          cycle_cnt;
    int          drain_cnt;
    logic [31:0] lfsr;
    logic [31:0] rnd;

    frame_loop_top i_frame_loop_top (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .payload_beats (payload_beats),
        .busy          (busy),
        .m_tdata       (m_tdata),
        .m_tstrb       (m_tstrb),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tlast       (m_tlast)
    );

    frame_checker i_frame_checker (
        .clk            (clk),
        .reset          (reset),
        .frame_start    (frame_start),
        .payload_beats  (payload_beats),
        .busy           (busy),
        .m_tdata        (m_tdata),
        .m_tstrb        (m_tstrb),
        .m_tvalid       (m_tvalid),
        .m_tready       (m_tready),
        .m_tlast        (m_tlast),
        .value_errors   (value_errors),
        .stall_errors   (stall_errors),
        .reset_errors   (reset_errors),
        .extra_beats    (extra_beats),
        .pending        (pending),
        .frames_started (frames_started),
        .frames_done    (frames_done)
    );

    always #4 clk = ~clk;

    ////////////////////
    // Random bits
    ////////////////////

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // One falling edge of stimulus with ready low about one cycle in four
    task automatic drive_cycle(input logic extra_ok);
        logic [31:0] r;
        @(negedge clk);
        take_bits(2, r);
        m_tready    = (r[1:0] != 2'b00);
        frame_start = 1'b0;
        if (extra_ok && busy) begin
            take_bits(3, r);
            if (r[2:0] == 3'b000) begin
                // The DUT must ignore this start while busy
                take_bits(5, r);
                frame_start   = 1'b1;
                payload_beats = frame_pkg::payload_len_t'(r[4:0]);
            end
        end
    endtask

    task automatic finish_run(input logic timed_out);
        int total;
        total = value_errors + stall_errors + reset_errors + extra_beats + other_failures;
        $display("Errors: value %0d, stall %0d, reset %0d, extra beats %0d, other %0d",
                 value_errors, stall_errors, reset_errors, extra_beats, other_failures);
        if (total == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    ////////////////////
    // Timeout
    ////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run(1'b1);
        end
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        frame_start    = 1'b0;
        payload_beats  = '0;
        m_tready       = 1'b0;
        lfsr           = 32'd32;
        other_failures = 0;
        cycle_cnt      = 0;
        drain_cnt      = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        for (int f = 0; f < FRAMES; f++) begin
            drive_cycle(1'b1);
            while (busy) begin
                drive_cycle(1'b1);
            end
            // Short frames first so partial wide beats show up early
            if (f < 5) begin
                payload_beats = frame_pkg::payload_len_t'(f + 1);
            end else begin
                take_bits(5, rnd);
                payload_beats = frame_pkg::payload_len_t'(rnd[4:0]) + 1'b1;
            end
            frame_start = 1'b1;
        end

        // Drain, then watch a little longer for stray beats
        drive_cycle(1'b0);
        while ((busy || pending != 0) && drain_cnt < DRAIN_LIMIT) begin
            drive_cycle(1'b0);
            drain_cnt++;
        end
        repeat (16) drive_cycle(1'b0);

        if (pending != 0) begin
            other_failures++;
            $display("The expected-beat queue still holds %0d beats at the end", pending);
        end
        if (frames_done != frames_started) begin
            other_failures++;
            $display("Frame count wrong: %0d starts accepted, %0d frames received",
                     frames_started, frames_done);
        end
        finish_run(1'b0);
    end

endmodule

/* verilog.f */
+incdir+source
source/axis_pkg.sv
source/frame_pkg.sv
source/axis_if.sv
source/frame_gen.sv
source/axis_upsizer.sv
source/axis_downsizer.sv
source/frame_loop_top.sv
tests/frame_checker.sv
tests/tb_frame_loop.sv

/* Bender.yml */
package:
  name: frame_loop

sources:
  - include_dirs:
      - source
    files:
      - source/axis_pkg.sv
      - source/frame_pkg.sv
      - source/axis_if.sv
      - source/frame_gen.sv
      - source/axis_upsizer.sv
      - source/axis_downsizer.sv
      - source/frame_loop_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/frame_checker.sv
      - tests/tb_frame_loop.sv
